/* design/ooo_pkg.sv */
// Widths, opcodes and bus structs shared by the rename slice; compile before every other file
`default_nettype none

package ooo_pkg;

  // Architectural register file
  localparam int NUM_ARCH_REGS = 32;
  localparam int REG_W = 5;
  localparam int XLEN = 32;

  // Reorder buffer sizing
  // Tags stay 7 bits wide, only the low ROB_PTR_W bits are ever nonzero
  localparam int ROBID_W = 7;
  localparam int ROB_DEPTH = 16;
  localparam int ROB_PTR_W = $clog2(ROB_DEPTH);
  localparam int ROB_CNT_W = ROB_PTR_W + 1;

  // RV32 major opcodes used by decode
  localparam int OPC_W = 7;
  localparam logic [OPC_W-1:0] OPC_LUI = 7'b0110111;
  localparam logic [OPC_W-1:0] OPC_AUIPC = 7'b0010111;
  localparam logic [OPC_W-1:0] OPC_JAL = 7'b1101111;
  localparam logic [OPC_W-1:0] OPC_OP = 7'b0110011;
  // No destination register for these two
  localparam logic [OPC_W-1:0] OPC_STORE = 7'b0100011;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;

  // Destination with a flag for "writes nothing"
  typedef struct packed {
    logic             none;
    logic [REG_W-1:0] idx;
  } dest_t;

  // Decode to rat
  typedef struct packed {
    logic               valid;
    dest_t              dest;
    logic [ROBID_W-1:0] robid;
    logic [REG_W-1:0]   rs1;
    logic [REG_W-1:0]   rs2;
  } rename_req_t;

  // Value when valid, otherwise tag in the low bits
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] tagval;
  } operand_t;

  // Common data bus result
  typedef struct packed {
    logic               valid;
    logic               error;
    logic [ROBID_W-1:0] robid;
    dest_t              dest;
    logic [XLEN-1:0]    result;
  } wb_t;

  // In-order retirement of one destination
  typedef struct packed {
    logic             valid;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  result;
  } retire_t;

  // Decode to rob
  typedef struct packed {
    logic  valid;
    dest_t dest;
  } alloc_t;

endpackage

`default_nettype wire

/* design/rat.sv */
// Register alias table; renames destinations and returns each source as value or producing tag
`default_nettype none

module rat (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ooo_pkg::rename_req_t ren_req,
  input  ooo_pkg::wb_t         wb,
  input  ooo_pkg::retire_t     retire,
  input  logic                 flush,
  output ooo_pkg::operand_t    rs1_op,
  output ooo_pkg::operand_t    rs2_op
);

  import ooo_pkg::*;

  // One source read, captured on the rename request
  typedef struct packed {
    logic [REG_W-1:0]   idx;
    logic [ROBID_W-1:0] tag;
    logic               valid;
    logic               committed;
    logic [XLEN-1:0]    spec;
    logic [XLEN-1:0]    comm;
  } src_rd_t;

  // Per-register arrays
  logic [ROBID_W-1:0]       tag_q      [NUM_ARCH_REGS];
  logic [XLEN-1:0]          spec_val_q [NUM_ARCH_REGS];
  logic [XLEN-1:0]          comm_val_q [NUM_ARCH_REGS];
  logic [NUM_ARCH_REGS-1:0] valid_q;
  logic [NUM_ARCH_REGS-1:0] committed_q;

  // Previous cycle's bus result
  logic                     wb_prev_write;
  logic [ROBID_W-1:0]       wb_prev_robid;
  logic [REG_W-1:0]         wb_prev_rd;
  logic [XLEN-1:0]          wb_prev_result;

  logic                     ld_tag;
  logic                     wb_write;
  logic                     ld_spec;

  // Index 0 is rs1, index 1 is rs2
  logic [REG_W-1:0]         src_idx [2];
  src_rd_t                  src_q   [2];
  logic [1:0]               fwd_prev;
  logic [1:0]               fwd_cur;
  operand_t                 src_op  [2];

  // New mapping only for real destinations
  assign ld_tag = ren_req.valid && !ren_req.dest.none;

  // Errored results and no-destination results never reach the table
  assign wb_write = wb.valid && !wb.error && !wb.dest.none;

  // Stale result if the register was renamed again since
  assign ld_spec = wb_prev_write && (tag_q[wb_prev_rd] == wb_prev_robid);

  assign src_idx[0] = ren_req.rs1;
  assign src_idx[1] = ren_req.rs2;

  // Bus result pipeline
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      wb_prev_write <= 1'b0;
    end else begin
      wb_prev_write <= wb_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_prev_robid  <= wb.robid;
    wb_prev_rd     <= wb.dest.idx;
    wb_prev_result <= wb.result;
  end

  // Tag and speculative value arrays
  always_ff @(posedge clk) begin
    if (ld_tag) begin
      tag_q[ren_req.dest.idx] <= ren_req.robid;
    end
    if (ld_spec) begin
      spec_val_q[wb_prev_rd] <= wb_prev_result;
    end
  end

  // Committed values, cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_ARCH_REGS; r++) begin
        comm_val_q[r] <= '0;
      end
    end else if (retire.valid) begin
      comm_val_q[retire.rd] <= retire.result;
    end
  end

  // Status bits
  // A rename in the same cycle as a spec write to that register wins
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid_q     <= '1;
      committed_q <= '1;
    end else begin
      if (ld_spec) begin
        valid_q[wb_prev_rd] <= 1'b1;
      end
      if (ld_tag) begin
        valid_q[ren_req.dest.idx]     <= 1'b0;
        committed_q[ren_req.dest.idx] <= 1'b0;
      end
    end
  end

  // Registered source reads
  // Writes landing this same edge are bypassed into the captured copy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < 2; s++) begin
        src_q[s] <= '0;
      end
    end else if (ren_req.valid) begin
      for (int s = 0; s < 2; s++) begin
        src_q[s].idx <= src_idx[s];
        src_q[s].tag <= tag_q[src_idx[s]];
        src_q[s].committed <= flush || committed_q[src_idx[s]];
        src_q[s].valid <= flush || valid_q[src_idx[s]] ||
                          (ld_spec && (wb_prev_rd == src_idx[s]));
        src_q[s].spec <= (ld_spec && (wb_prev_rd == src_idx[s])) ?
                         wb_prev_result : spec_val_q[src_idx[s]];
        src_q[s].comm <= (retire.valid && (retire.rd == src_idx[s])) ?
                         retire.result : comm_val_q[src_idx[s]];
      end
    end
  end

  // Operand select with forwarding from the previous and current bus
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      fwd_prev[s] = wb_prev_write && (wb_prev_robid == src_q[s].tag);
      fwd_cur[s]  = wb_write && (wb.robid == src_q[s].tag);
      src_op[s].valid = src_q[s].valid || fwd_prev[s] || fwd_cur[s];
      if (src_q[s].committed) begin
        src_op[s].tagval = src_q[s].comm;
      end else if (src_q[s].valid) begin
        src_op[s].tagval = src_q[s].spec;
      end else if (fwd_prev[s]) begin
        // Older result first, it was on the bus a cycle earlier
        src_op[s].tagval = wb_prev_result;
      end else if (fwd_cur[s]) begin
        src_op[s].tagval = wb.result;
      end else begin
        src_op[s].tagval = XLEN'(src_q[s].tag);
      end
      // x0 is hardwired
      if (src_q[s].idx == '0) begin
        src_op[s].valid  = 1'b1;
        src_op[s].tagval = '0;
      end
    end
  end

  assign rs1_op = src_op[0];
  assign rs2_op = src_op[1];

endmodule

`default_nettype wire

/* design/rename_core.sv */
// Top of the rename and retirement slice; instructions and bus results in, operands and retires out
`default_nettype none

module rename_core (
  input  logic                clk,
  input  logic                rst_n,
  // Instruction strobe, held off while rob_full is high
  input  logic                inst_valid,
  input  logic [31:0]         inst,
  // Results from execution, at most one per cycle
  input  ooo_pkg::wb_t        wb,
  // Operands, one cycle after inst_valid
  output ooo_pkg::operand_t   rs1_op,
  output ooo_pkg::operand_t   rs2_op,
  output ooo_pkg::retire_t    retire_out,
  output logic                flush,
  output logic                rob_full
);

  import ooo_pkg::*;

  rename_req_t        ren_req;
  alloc_t             alloc;
  logic [ROBID_W-1:0] rob_tail;

  // Field extraction and id stamping
  rename_decode i_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rob_tail   (rob_tail),
    .flush      (flush),
    .ren_req    (ren_req),
    .alloc      (alloc)
  );

  // Alias table, also fed back by retirement
  rat i_rat (
    .clk     (clk),
    .rst_n   (rst_n),
    .ren_req (ren_req),
    .wb      (wb),
    .retire  (retire_out),
    .flush   (flush),
    .rs1_op  (rs1_op),
    .rs2_op  (rs2_op)
  );

  // In-order completion
  rob i_rob (
    .clk      (clk),
    .rst_n    (rst_n),
    .alloc    (alloc),
    .wb       (wb),
    .tail     (rob_tail),
    .rob_full (rob_full),
    .retire   (retire_out),
    .flush    (flush)
  );

endmodule

`default_nettype wire

/* design/rename_decode.sv */
// Instruction field decode feeding the rat and rob; combinational apart from its copy of the rob tail
`default_nettype none

module rename_decode (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        inst_valid,
  input  logic [31:0]                 inst,
  input  logic [ooo_pkg::ROBID_W-1:0] rob_tail,
  input  logic                        flush,
  output ooo_pkg::rename_req_t        ren_req,
  output ooo_pkg::alloc_t             alloc
);

  import ooo_pkg::*;

  logic [OPC_W-1:0]     opcode;
  logic [REG_W-1:0]     rd_fld;
  logic [REG_W-1:0]     rs1_fld;
  logic [REG_W-1:0]     rs2_fld;
  logic                 uses_rs1;
  logic                 uses_rs2;
  logic                 take;
  dest_t                dest;
  logic [ROB_PTR_W-1:0] tail_q;

  // Fixed RV32 field positions
  assign opcode  = inst[6:0];
  assign rd_fld  = inst[11:7];
  assign rs1_fld = inst[19:15];
  assign rs2_fld = inst[24:20];

  // U and J formats have no rs1
  assign uses_rs1 = !(opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL});
  // Only R, S and B formats carry rs2
  assign uses_rs2 = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};

  // Stores, branches and writes to x0 leave the register file alone
  assign dest.none = (opcode inside {OPC_STORE, OPC_BRANCH}) || (rd_fld == '0);
  assign dest.idx  = rd_fld;

  // Instruction in the flush cycle is dropped
  assign take = inst_valid && !flush;

  // Mirror of the rob tail, advances one cycle after each allocation
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail_q <= '0;
    end else if (flush) begin
      // Rob has already emptied, pick up where its tail sits
      tail_q <= rob_tail[ROB_PTR_W-1:0];
    end else if (take) begin
      tail_q <= tail_q + 1'b1;
    end
  end

  always_comb begin
    ren_req.valid = take;
    ren_req.dest  = dest;
    ren_req.robid = ROBID_W'(tail_q);
    // Unused sources read x0
    ren_req.rs1   = uses_rs1 ? rs1_fld : '0;
    ren_req.rs2   = uses_rs2 ? rs2_fld : '0;
  end

  // Every instruction takes a rob entry, with or without a destination
  assign alloc.valid = take;
  assign alloc.dest  = dest;

endmodule

`default_nettype wire

/* design/rob.sv */
// Circular reorder buffer; collects bus results and retires them in program order or flushes
`default_nettype none

module rob (
  input  logic                        clk,
  input  logic                        rst_n,
  input  ooo_pkg::alloc_t             alloc,
  input  ooo_pkg::wb_t                wb,
  output logic [ooo_pkg::ROBID_W-1:0] tail,
  output logic                        rob_full,
  output ooo_pkg::retire_t            retire,
  output logic                        flush
);

  import ooo_pkg::*;

  // Pointers and occupancy
  logic [ROB_PTR_W-1:0] head_q;
  logic [ROB_PTR_W-1:0] tail_q;
  logic [ROB_PTR_W-1:0] tail_next;
  logic [ROB_CNT_W-1:0] count_q;

  // Entry storage
  dest_t                dest_q   [ROB_DEPTH];
  logic [XLEN-1:0]      result_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done_q;
  logic [ROB_DEPTH-1:0] err_q;

  // Registered retire and flush outputs
  logic                 ret_valid_q;
  logic [REG_W-1:0]     ret_rd_q;
  logic [XLEN-1:0]      ret_result_q;
  logic                 flush_q;

  logic [ROB_PTR_W-1:0] wb_slot;
  logic                 head_ready;

  assign wb_slot    = wb.robid[ROB_PTR_W-1:0];
  assign tail_next  = tail_q + ROB_PTR_W'(alloc.valid);
  assign head_ready = (count_q != '0) && done_q[head_q];

  // Pointer and count update
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q      <= '0;
      tail_q      <= '0;
      count_q     <= '0;
      ret_valid_q <= 1'b0;
      flush_q     <= 1'b0;
    end else begin
      ret_valid_q <= 1'b0;
      flush_q     <= 1'b0;
      if (head_ready && err_q[head_q]) begin
        // Errored head, drop everything including this cycle's allocation
        flush_q <= 1'b1;
        head_q  <= tail_next;
        tail_q  <= tail_next;
        count_q <= '0;
      end else begin
        tail_q  <= tail_next;
        count_q <= count_q + ROB_CNT_W'(alloc.valid) - ROB_CNT_W'(head_ready);
        if (head_ready) begin
          head_q <= head_q + 1'b1;
          // No strobe for stores and branches
          ret_valid_q <= !dest_q[head_q].none;
        end
      end
    end
  end

  // Completion bits, cleared on allocation
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= '0;
      err_q  <= '0;
    end else begin
      if (alloc.valid) begin
        done_q[tail_q] <= 1'b0;
        err_q[tail_q]  <= 1'b0;
      end
      if (wb.valid) begin
        done_q[wb_slot] <= 1'b1;
        err_q[wb_slot]  <= wb.error;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (alloc.valid) begin
      dest_q[tail_q] <= alloc.dest;
    end
    if (wb.valid) begin
      result_q[wb_slot] <= wb.result;
    end
    if (head_ready) begin
      ret_rd_q     <= dest_q[head_q].idx;
      ret_result_q <= result_q[head_q];
    end
  end

  assign tail     = ROBID_W'(tail_q);
  assign rob_full = (count_q == ROB_CNT_W'(ROB_DEPTH));
  assign flush    = flush_q;

  always_comb begin
    retire.valid  = ret_valid_q;
    retire.rd     = ret_rd_q;
    retire.result = ret_result_q;
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the rename slice testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module rename_core_tb -Mdir "$BUILD_DIR" -o rename_core_sim -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/rename_core_sim" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "sim failed" "$LOG_FILE"; then
  exit 1
fi
if ! grep -q "sim passed" "$LOG_FILE"; then
  echo "No pass line found in $LOG_FILE"
  exit 1
fi
exit 0

/* sim/rename_core_asserts.sv */
// Structural checks on rob and rat that the bind lines at the bottom attach to both
`default_nettype none

module rename_core_asserts (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          flush,
  input logic                          rob_full,
  input logic                          ret_valid,
  input logic                          adv,
  input logic [ooo_pkg::ROB_PTR_W-1:0] head,
  input logic                          x0_rs1,
  input logic                          x0_rs2,
  input ooo_pkg::operand_t             rs1_op,
  input ooo_pkg::operand_t             rs2_op
);

  import ooo_pkg::*;

  // Head slot of the latest retirement since reset or flush
  logic [ROB_PTR_W-1:0] last_head;
  logic                 have_last;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      last_head <= '0;
      have_last <= 1'b0;
    end else if (adv) begin
      last_head <= head;
      have_last <= 1'b1;
    end
  end

  // Flush is a single pulse
  flush_pulse: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !flush)
    else $error("flush stayed high for two cycles");

  // Buffer is empty right after a flush
  flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> (!rob_full && !ret_valid))
    else $error("retire or full buffer in the cycle after a flush");

  // Each retirement takes the slot after the previous one
  retire_order: assert property (@(posedge clk) disable iff (!rst_n)
    (adv && have_last) |-> (head == ROB_PTR_W'(last_head + 1'b1)))
    else $error("retirement skipped an entry");

  // Source read of x0 comes back as a valid zero
  x0_rs1_zero: assert property (@(posedge clk) disable iff (!rst_n)
    x0_rs1 |=> (rs1_op.valid && rs1_op.tagval == '0))
    else $error("rs1 read of x0 was not a valid zero");
  x0_rs2_zero: assert property (@(posedge clk) disable iff (!rst_n)
    x0_rs2 |=> (rs2_op.valid && rs2_op.tagval == '0))
    else $error("rs2 read of x0 was not a valid zero");

endmodule

bind rob rename_core_asserts i_asserts (
  .clk(clk), .rst_n(rst_n), .flush(flush_q), .rob_full(rob_full), .ret_valid(ret_valid_q),
  .adv(head_ready && !err_q[head_q]), .head(head_q), .x0_rs1(1'b0), .x0_rs2(1'b0),
  .rs1_op('0), .rs2_op('0)
);

bind rat rename_core_asserts i_asserts (
  .clk(clk), .rst_n(rst_n), .flush(flush), .rob_full(1'b0), .ret_valid(retire.valid),
  .adv(1'b0), .head('0),
  .x0_rs1(ren_req.valid && ren_req.rs1 == '0),
  .x0_rs2(ren_req.valid && ren_req.rs2 == '0),
  .rs1_op(rs1_op), .rs2_op(rs2_op)
);

`default_nettype wire

/* sim/rename_core_tb.sv */
// Self-checking testbench for rename_core; random instructions and results against a cycle model
`default_nettype none

module rename_core_tb;

  import ooo_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int RUN_CYCLES   = 4000;
  // No results early on so the buffer fills up
  localparam int FILL_CYCLES  = 40;
  localparam int DRAIN_LIMIT  = 1000;
  // Opening branches read every register once
  localparam int SWEEP_CYCLES = NUM_ARCH_REGS / 2;

  typedef struct packed {
    logic [ROBID_W-1:0] id;
    dest_t              dest;
    logic               sent;
    logic               done;
    logic               err;
    logic [XLEN-1:0]    result;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        inst_valid;
  logic [31:0] inst;
  wb_t         wb;
  operand_t    rs1_op;
  operand_t    rs2_op;
  retire_t     retire_out;
  logic        flush;
  logic        rob_full;

  integer seed;
  int     errors;
  int     checks;
  int     cycle;
  int     drain_cnt;
  bit     draining;

  // Architectural and speculative state
  logic [ROBID_W-1:0]       m_tag  [NUM_ARCH_REGS];
  logic [XLEN-1:0]          m_spec [NUM_ARCH_REGS];
  logic [XLEN-1:0]          m_comm [NUM_ARCH_REGS];
  logic [NUM_ARCH_REGS-1:0] m_vld;
  logic [NUM_ARCH_REGS-1:0] m_cmt;
  // Outstanding ids in age order
  entry_t                   rob_q[$];
  logic [ROBID_W-1:0]       next_id;

  // Inputs driven for the running cycle
  logic             drv_inst;
  dest_t            drv_dest;
  logic [REG_W-1:0] drv_src [2];
  wb_t              drv_wb;

  // Bus result held one cycle by the rat
  wb_t  prev_wb;
  logic prev_write;

  // Expected outputs of the running cycle
  logic               exp_chk;
  logic [1:0]         exp_pend;
  operand_t           exp_op  [2];
  logic [ROBID_W-1:0] exp_tag [2];
  retire_t            exp_ret;
  logic               exp_flush;
  logic               exp_full;

  rename_core i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb         (wb),
    .rs1_op     (rs1_op),
    .rs2_op     (rs2_op),
    .retire_out (retire_out),
    .flush      (flush),
    .rob_full   (rob_full)
  );

  always #5 clk = ~clk;

  // Full flag follows the outstanding count
  full_matches: assert property (@(negedge clk) disable iff (!rst_n) rob_full == exp_full)
    else begin
      errors++;
      $display("Fail rob_full expected %h actual %h", exp_full, rob_full);
    end

  // Results that reach the alias table
  function automatic logic writes_table(wb_t w);
    return w.valid && !w.error && !w.dest.none;
  endfunction

  function automatic logic [6:0] pick_opcode();
    case ($unsigned($random(seed)) % 7)
      0: return OPC_OP;
      1: return 7'b0010011;
      2: return 7'b0000011;
      3: return OPC_LUI;
      4: return OPC_JAL;
      5: return OPC_STORE;
      default: return OPC_BRANCH;
    endcase
  endfunction

  task automatic reset_model();
    for (int r = 0; r < NUM_ARCH_REGS; r++) begin
      m_tag[r]  = '0;
      m_spec[r] = '0;
      m_comm[r] = '0;
    end
    m_vld      = '1;
    m_cmt      = '1;
    rob_q.delete();
    next_id    = '0;
    drv_inst   = 1'b0;
    drv_dest   = '0;
    drv_src[0] = '0;
    drv_src[1] = '0;
    drv_wb     = '0;
    prev_wb    = '0;
    prev_write = 1'b0;
    exp_chk    = 1'b0;
    exp_pend   = '0;
    exp_ret    = '0;
    exp_flush  = 1'b0;
    exp_full   = 1'b0;
  endtask

  // Advance the model over the clock edge that closes a cycle
  task automatic update_model();
    logic [REG_W-1:0] idx;
    retire_t          nxt_ret;
    logic             nxt_flush;
    entry_t           e;
    // Result from two cycles back lands unless the register was renamed since
    if (prev_write && m_tag[prev_wb.dest.idx] == prev_wb.robid) begin
      m_spec[prev_wb.dest.idx] = prev_wb.result;
      m_vld[prev_wb.dest.idx]  = 1'b1;
    end
    if (exp_ret.valid) begin
      m_comm[exp_ret.rd] = exp_ret.result;
    end
    // Sources see the table before their own rename
    exp_chk  = drv_inst;
    exp_pend = '0;
    if (drv_inst) begin
      for (int s = 0; s < 2; s++) begin
        idx = drv_src[s];
        if (idx == '0) begin
          exp_op[s] = '{1'b1, '0};
        end else if (m_cmt[idx]) begin
          exp_op[s] = '{1'b1, m_comm[idx]};
        end else if (m_vld[idx]) begin
          exp_op[s] = '{1'b1, m_spec[idx]};
        end else begin
          exp_pend[s] = 1'b1;
          exp_tag[s]  = m_tag[idx];
        end
      end
      if (!drv_dest.none) begin
        m_tag[drv_dest.idx] = next_id;
        m_vld[drv_dest.idx] = 1'b0;
        m_cmt[drv_dest.idx] = 1'b0;
      end
    end
    if (exp_flush) begin
      m_vld      = '1;
      m_cmt      = '1;
      prev_write = 1'b0;
    end else begin
      prev_write = writes_table(drv_wb);
      prev_wb    = drv_wb;
    end
    // Head entry that was already done retires or flushes
    nxt_ret   = '0;
    nxt_flush = 1'b0;
    if (rob_q.size() > 0 && rob_q[0].done) begin
      if (rob_q[0].err) begin
        nxt_flush = 1'b1;
      end else begin
        nxt_ret.valid  = !rob_q[0].dest.none;
        nxt_ret.rd     = rob_q[0].dest.idx;
        nxt_ret.result = rob_q[0].result;
        void'(rob_q.pop_front());
      end
    end
    if (drv_wb.valid) begin
      foreach (rob_q[i]) begin
        if (rob_q[i].id == drv_wb.robid) begin
          rob_q[i].done   = 1'b1;
          rob_q[i].err    = drv_wb.error;
          rob_q[i].result = drv_wb.result;
        end
      end
    end
    if (drv_inst) begin
      e      = '0;
      e.id   = next_id;
      e.dest = drv_dest;
      rob_q.push_back(e);
      next_id = ROBID_W'((int'(next_id) + 1) % ROB_DEPTH);
    end
    if (nxt_flush) begin
      rob_q.delete();
    end
    exp_ret   = nxt_ret;
    exp_flush = nxt_flush;
    exp_full  = (rob_q.size() == ROB_DEPTH);
  endtask

  // Pick this cycle's instruction and result
  task automatic drive_inputs();
    logic             hold;
    logic [6:0]       opc;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [31:0]      word;
    int               open_idx[$];
    int               k;
    wb_t              w;
    // Quiet around a flush since the errored head drops everything
    hold = exp_flush || (rob_q.size() > 0 && rob_q[0].done && rob_q[0].err);
    word = '0;
    w    = '0;
    drv_inst = 1'b0;
    if (!hold && !draining && !exp_full &&
        (cycle < SWEEP_CYCLES || ($random(seed) & 3) != 0)) begin
      if (cycle < SWEEP_CYCLES) begin
        // Branch without destination reads two untouched registers
        opc = OPC_BRANCH;
        rd  = '0;
        rs1 = REG_W'(2 * cycle);
        rs2 = REG_W'(2 * cycle + 1);
      end else begin
        opc = pick_opcode();
        // Few registers for many collisions
        rd  = REG_W'($random(seed) & 7);
        rs1 = REG_W'($random(seed) & 7);
        rs2 = REG_W'($random(seed) & 7);
      end
      word = {7'b0, rs2, rs1, 3'b0, rd, opc};
      drv_inst      = 1'b1;
      drv_dest.none = (opc == OPC_STORE) || (opc == OPC_BRANCH) || (rd == '0);
      drv_dest.idx  = rd;
      drv_src[0]    = (opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL}) ? '0 : rs1;
      drv_src[1]    = (opc inside {OPC_OP, OPC_STORE, OPC_BRANCH}) ? rs2 : '0;
    end
    if (!hold && (cycle >= FILL_CYCLES || draining) && ($random(seed) & 1) != 0) begin
      foreach (rob_q[i]) begin
        if (!rob_q[i].sent) begin
          open_idx.push_back(i);
        end
      end
      if (open_idx.size() > 0) begin
        k = open_idx[$unsigned($random(seed)) % open_idx.size()];
        rob_q[k].sent = 1'b1;
        w.valid  = 1'b1;
        w.error  = ($random(seed) & 15) == 0;
        w.robid  = rob_q[k].id;
        w.dest   = rob_q[k].dest;
        w.result = $random(seed);
      end
    end
    drv_wb = w;
    inst_valid <= drv_inst;
    inst       <= word;
    wb         <= w;
  endtask

  task automatic check_outputs();
    operand_t expv;
    operand_t act;
    if (exp_chk) begin
      for (int s = 0; s < 2; s++) begin
        expv = exp_op[s];
        // Producer result on the bus last cycle or this one
        if (exp_pend[s]) begin
          if (prev_write && prev_wb.robid == exp_tag[s]) begin
            expv = '{1'b1, prev_wb.result};
          end else if (writes_table(drv_wb) && drv_wb.robid == exp_tag[s]) begin
            expv = '{1'b1, drv_wb.result};
          end else begin
            expv = '{1'b0, XLEN'(exp_tag[s])};
          end
        end
        act = (s == 0) ? rs1_op : rs2_op;
        checks++;
        assert (act === expv) else begin
          errors++;
          $display("Fail rs%0d_op expected %h actual %h", s + 1, expv, act);
        end
      end
    end
    checks++;
    assert (flush === exp_flush) else begin
      errors++;
      $display("Fail flush expected %h actual %h", exp_flush, flush);
    end
    assert (retire_out.valid === exp_ret.valid) else begin
      errors++;
      $display("Fail retire_out.valid expected %h actual %h", exp_ret.valid, retire_out.valid);
    end
    if (exp_ret.valid) begin
      assert (retire_out.rd === exp_ret.rd && retire_out.result === exp_ret.result) else begin
        errors++;
        $display("Fail retire_out expected %h actual %h", exp_ret, retire_out);
      end
    end
  endtask

  initial begin
    seed       = 59;
    errors     = 0;
    checks     = 0;
    cycle      = 0;
    drain_cnt  = 0;
    draining   = 1'b0;
    clk        = 1'b0;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    wb         = '0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (cycle = 0; cycle < RUN_CYCLES; cycle++) begin
      @(posedge clk);
      update_model();
      drive_inputs();
      @(negedge clk);
      check_outputs();
    end
    // Results only until every id has left the buffer
    draining = 1'b1;
    while ((rob_q.size() > 0 || exp_flush || exp_ret.valid || drv_inst) &&
           drain_cnt < DRAIN_LIMIT) begin
      @(posedge clk);
      update_model();
      drive_inputs();
      @(negedge clk);
      check_outputs();
      drain_cnt++;
    end
    if (drain_cnt >= DRAIN_LIMIT) begin
      errors++;
      $display("Timeout while waiting for the reorder buffer to drain");
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
design/ooo_pkg.sv
design/rename_decode.sv
design/rat.sv
design/rob.sv
design/rename_core.sv
sim/rename_core_asserts.sv
sim/rename_core_tb.sv
